// File: list.f
+incdir+include
hdl/heap_pkg.sv
hdl/axil_pkg.sv
hdl/axis_to_memory.sv
hdl/heap_bram.sv
hdl/heap_ctrl_regs.sv
hdl/axis_heap_top.sv
testbench/heap_checker.sv
testbench/tb_axis_heap.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of tb_axis_heap; the exit status follows the result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_axis_heap -o sim_axis_heap \
    && ./obj_dir/sim_axis_heap | tee /dev/stderr | grep -q "^PASS: all tests$" \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }

// File: testbench/tb_axis_heap.sv
// testbench top: clock, reset, stream and AXI4-Lite stimulus, test sequence.
`include "heap_settings.svh"

module tb_axis_heap;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200; // cycles per wait.

    logic                 axis_clk = 1'b0;
    logic                 axis_aresetn;
    logic                 axis_tlast, axis_tvalid, axis_tready;
    heap_pkg::heap_word_t axis_tdata;
    heap_pkg::heap_strb_t axis_tkeep;
    logic                 s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic                 s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic                 s_axil_rvalid, s_axil_rready;
    logic [3:0]           s_axil_wstrb;
    axil_pkg::axil_addr_t s_axil_awaddr, s_axil_araddr;
    axil_pkg::axil_data_t s_axil_wdata, s_axil_rdata;
    axil_pkg::axil_resp_t s_axil_bresp, s_axil_rresp;
    int                   seed = 68;
    int                   tb_errors = 0;
    int                   check_errors;
    logic                 busy_seen;
    logic                 stream_done;

    always #5 axis_clk = ~axis_clk;

    axis_heap_top UUT (.*);

    heap_checker u_check (.*, .error_count(check_errors));

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // ------------------------------------------------------------------
    // AXI4-Lite master
    // ------------------------------------------------------------------
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int n;
        @(posedge axis_clk);
        s_axil_awaddr  <= addr[`AXIL_ADDR_BITS-1:0];
        s_axil_wdata   <= data;
        s_axil_wstrb   <= strb;
        s_axil_awvalid <= 1'b1;
        s_axil_wvalid  <= 1'b1;
        s_axil_bready  <= 1'b1;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!s_axil_awready && n < TIMEOUT);
        if (!s_axil_awready) abort_on_timeout("write address handshake");
        s_axil_awvalid <= 1'b0;
        s_axil_wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!s_axil_bvalid && n < TIMEOUT);
        if (!s_axil_bvalid) abort_on_timeout("write response");
        s_axil_bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data);
        int n;
        @(posedge axis_clk);
        s_axil_araddr  <= addr[`AXIL_ADDR_BITS-1:0];
        s_axil_arvalid <= 1'b1;
        s_axil_rready  <= 1'b1;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!s_axil_arready && n < TIMEOUT);
        if (!s_axil_arready) abort_on_timeout("read address handshake");
        s_axil_arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!s_axil_rvalid && n < TIMEOUT);
        if (!s_axil_rvalid) abort_on_timeout("read response");
        data = s_axil_rdata;
        s_axil_rready <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // stream source, never sees back-pressure
    // ------------------------------------------------------------------
    task automatic send_packet(input int len, input bit rand_keep, input int max_gap);
        int gap;
        for (int i = 0; i < len; i++) begin
            gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
            repeat (gap) begin
                @(posedge axis_clk);
                axis_tvalid <= 1'b0;
            end
            @(posedge axis_clk);
            axis_tvalid <= 1'b1;
            axis_tdata  <= $random(seed);
            axis_tkeep  <= rand_keep ? 4'($random(seed)) : 4'hF;
            axis_tlast  <= (i == len - 1);
        end
        @(posedge axis_clk);
        axis_tvalid <= 1'b0;
        axis_tlast  <= 1'b0;
    endtask

    task automatic read_back(input heap_pkg::heap_byte_addr_t start, input int len);
        logic [31:0]               data;
        heap_pkg::heap_byte_addr_t a;
        for (int i = 0; i < len; i++) begin
            a = {start[`HEAP_ADDR_BITS-1:2], 2'b00} + heap_pkg::heap_byte_addr_t'(4 * i);
            axil_read(`HEAP_WINDOW_BASE + 32'(a), data);
        end
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0]               rd;
        heap_pkg::heap_byte_addr_t start;
        int                        len;
        int                        n;
        axis_aresetn   = 1'b0;
        axis_tdata     = '0;
        axis_tkeep     = '0;
        axis_tlast     = 1'b0;
        axis_tvalid    = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;

        u_check.test_name = "reset";
        repeat (8) @(posedge axis_clk);
        if (axis_tready || s_axil_bvalid || s_axil_rvalid || s_axil_awready || s_axil_wready ||
            s_axil_arready) begin
            tb_errors++;
            $display("reset: a ready or valid output is high while reset is held");
        end
        axis_aresetn <= 1'b1;
        n = 0;
        do begin
            @(posedge axis_clk);
            n++;
        end while (!axis_tready && n < TIMEOUT);
        if (!axis_tready) abort_on_timeout("tready rising after reset");
        axil_read(`REG_START_ADDR, rd);
        axil_read(`REG_PKT_COUNT, rd);
        axil_read(`REG_BEAT_COUNT, rd);

        u_check.test_name = "registers";
        axil_write(`REG_START_ADDR, 32'h0000_0A37, 4'hF);
        axil_read(`REG_START_ADDR, rd);
        axil_write(`REG_START_ADDR, 32'hFFFF_F5FF, 4'b0010); // only bits 11:8 change.
        axil_read(`REG_START_ADDR, rd);
        axil_write(`REG_PKT_COUNT, 32'h0000_1234, 4'hF);
        axil_write(32'h0000_0010, 32'h0000_0001, 4'hF);
        axil_read(32'h0000_0010, rd);

        u_check.test_name = "packet";
        start = heap_pkg::heap_byte_addr_t'($random(seed)) & 12'hFFC;
        len   = 4 + int'($unsigned($random(seed)) % 29);
        axil_write(`REG_START_ADDR, 32'(start), 4'hF);
        send_packet(len, 1'b0, 0);
        read_back(start, len);
        axil_read(`REG_PKT_COUNT, rd);
        axil_read(`REG_BEAT_COUNT, rd);

        // same region again, untouched lanes keep the first packet.
        u_check.test_name = "tkeep";
        send_packet(len, 1'b1, 0);
        read_back(start, len);

        u_check.test_name = "gaps";
        start = 12'h200;
        axil_write(`REG_START_ADDR, 32'(start), 4'hF);
        stream_done = 1'b0;
        busy_seen   = 1'b0;
        fork
            begin
                send_packet(24, 1'b0, 3);
                stream_done = 1'b1;
            end
            begin
                n = 0;
                while (!stream_done && n < TIMEOUT) begin
                    axil_read(`REG_STATUS, rd);
                    if (rd[0]) busy_seen = 1'b1;
                    n++;
                end
                if (!stream_done) abort_on_timeout("end of the gapped packet");
            end
        join
        if (!busy_seen) begin
            tb_errors++;
            $display("gaps: STATUS never showed the writer busy during the packet");
        end
        read_back(start, 24);

        u_check.test_name = "wrap";
        start = 12'hFF0; // four words below the top.
        axil_write(`REG_START_ADDR, 32'(start), 4'hF);
        send_packet(8, 1'b0, 0);
        read_back(start, 8);
        axil_read(`REG_PKT_COUNT, rd);
        axil_read(`REG_BEAT_COUNT, rd);

        repeat (2) @(posedge axis_clk);
        $display("errors: %0d in responses, %0d in testbench checks", check_errors, tb_errors);
        if (check_errors == 0 && tb_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: testbench/heap_checker.sv
// testbench checker: shadow heap and registers, reference functions, response comparison.
`include "heap_settings.svh"

module heap_checker (
    input  logic                 axis_clk,
    input  logic                 axis_aresetn,
    input  heap_pkg::heap_word_t axis_tdata,
    input  heap_pkg::heap_strb_t axis_tkeep,
    input  logic                 axis_tlast, axis_tvalid, axis_tready,
    input  axil_pkg::axil_addr_t s_axil_awaddr, s_axil_araddr,
    input  axil_pkg::axil_data_t s_axil_wdata, s_axil_rdata,
    input  logic [3:0]           s_axil_wstrb,
    input  axil_pkg::axil_resp_t s_axil_bresp, s_axil_rresp,
    input  logic                 s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready,
    input  logic                 s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready,
    input  logic                 s_axil_rvalid, s_axil_rready,
    output int                   error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    string                     test_name = "none";
    heap_pkg::heap_word_t      shadow_heap [`HEAP_DEPTH_WORDS];
    heap_pkg::heap_byte_addr_t shadow_start;
    heap_pkg::heap_byte_addr_t last_addr;
    logic                      in_pkt; // also the expected busy flag.
    axil_pkg::axil_data_t      shadow_pkts;
    axil_pkg::axil_data_t      shadow_beats;
    axil_pkg::axil_data_t      exp_rdata;
    axil_pkg::axil_resp_t      exp_rresp;
    axil_pkg::axil_resp_t      exp_bresp;

    // only lanes with tkeep set take the new byte.
    function automatic heap_pkg::heap_word_t expected_word(input heap_pkg::heap_word_t old_word,
                                                            input heap_pkg::heap_word_t data,
                                                            input heap_pkg::heap_strb_t keep);
        heap_pkg::heap_word_t w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (keep[b]) w[b*8 +: 8] = data[b*8 +: 8];
        end
        return w;
    endfunction

    // first beat at the aligned start, then 4 bytes on, wrapping at the top.
    function automatic heap_pkg::heap_byte_addr_t beat_addr(input logic first,
                                                            input heap_pkg::heap_byte_addr_t start,
                                                            input heap_pkg::heap_byte_addr_t prev);
        if (first) return {start[`HEAP_ADDR_BITS-1:2], 2'b00};
        return prev + heap_pkg::heap_byte_addr_t'(4);
    endfunction

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("Mismatch %s %s: expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // model update and response checks
    // ------------------------------------------------------------------
    always @(posedge axis_clk) begin
        heap_pkg::heap_byte_addr_t a;
        logic [31:0]               offset;
        if (!axis_aresetn) begin
            error_count  = 0;
            shadow_start <= '0;
            last_addr    <= '0;
            in_pkt       <= 1'b0;
            shadow_pkts  <= '0;
            shadow_beats <= '0;
        end else begin
            if (axis_tvalid && axis_tready) begin
                a = beat_addr(!in_pkt, shadow_start, last_addr);
                shadow_heap[a[`HEAP_ADDR_BITS-1:2]] <=
                    expected_word(shadow_heap[a[`HEAP_ADDR_BITS-1:2]], axis_tdata, axis_tkeep);
                last_addr    <= a;
                in_pkt       <= !axis_tlast;
                shadow_beats <= shadow_beats + 1;
                if (axis_tlast) shadow_pkts <= shadow_pkts + 1;
            end
            if (s_axil_awvalid && s_axil_wvalid && (s_axil_awready !== s_axil_wready)) begin
                error_count++;
                $display("%s: awready and wready did not pulse together", test_name);
            end
            if (s_axil_awvalid && s_axil_awready && s_axil_wvalid && s_axil_wready) begin
                exp_bresp <= axil_pkg::SLVERR;
                if (s_axil_awaddr[`AXIL_ADDR_BITS-1:2] == '0) begin
                    exp_bresp    <= axil_pkg::OKAY;
                    // strobed bytes only, cut to the register width.
                    shadow_start <= heap_pkg::heap_byte_addr_t'(
                        expected_word(32'(shadow_start), s_axil_wdata, s_axil_wstrb));
                end
            end
            if (s_axil_bvalid && s_axil_bready) compare_value("bresp", exp_bresp, s_axil_bresp);
            if (s_axil_arvalid && s_axil_arready) begin
                offset    = 32'({s_axil_araddr[`AXIL_ADDR_BITS-1:2], 2'b00});
                exp_rresp <= axil_pkg::OKAY;
                if (offset >= `HEAP_WINDOW_BASE) begin
                    exp_rdata <= shadow_heap[offset[`HEAP_ADDR_BITS-1:2]];
                end else begin
                    case (offset)
                        `REG_START_ADDR: exp_rdata <= 32'(shadow_start);
                        `REG_PKT_COUNT:  exp_rdata <= shadow_pkts;
                        `REG_BEAT_COUNT: exp_rdata <= shadow_beats;
                        `REG_STATUS:     exp_rdata <= {31'b0, in_pkt};
                        default: begin
                            exp_rdata <= '0;
                            exp_rresp <= axil_pkg::SLVERR;
                        end
                    endcase
                end
            end
            if (s_axil_rvalid && s_axil_rready) begin
                compare_value("rdata", exp_rdata, s_axil_rdata);
                compare_value("rresp", exp_rresp, s_axil_rresp);
            end
        end
    end

endmodule

// File: hdl/axis_heap_top.sv
// top level: stream writer, heap memory and AXI4-Lite control slave.
module axis_heap_top (
    input  logic                 axis_clk,
    input  logic                 axis_aresetn,

    input  heap_pkg::heap_word_t axis_tdata,
    input  heap_pkg::heap_strb_t axis_tkeep,
    input  logic                 axis_tlast,
    input  logic                 axis_tvalid,
    output logic                 axis_tready,

    input  axil_pkg::axil_addr_t s_axil_awaddr,
    input  logic                 s_axil_awvalid,
    output logic                 s_axil_awready,
    input  axil_pkg::axil_data_t s_axil_wdata,
    input  logic [3:0]           s_axil_wstrb,
    input  logic                 s_axil_wvalid,
    output logic                 s_axil_wready,
    output axil_pkg::axil_resp_t s_axil_bresp,
    output logic                 s_axil_bvalid,
    input  logic                 s_axil_bready,
    input  axil_pkg::axil_addr_t s_axil_araddr,
    input  logic                 s_axil_arvalid,
    output logic                 s_axil_arready,
    output axil_pkg::axil_data_t s_axil_rdata,
    output axil_pkg::axil_resp_t s_axil_rresp,
    output logic                 s_axil_rvalid,
    input  logic                 s_axil_rready
);

    heap_pkg::heap_byte_addr_t heap_wr_start_addr;
    heap_pkg::heap_byte_addr_t heap_a_addr;
    heap_pkg::heap_word_t      heap_a_wr_data;
    heap_pkg::heap_strb_t      heap_a_wr_en;
    heap_pkg::heap_byte_addr_t heap_b_addr;
    heap_pkg::heap_word_t      heap_b_rd_data;
    axil_pkg::axil_data_t      pkt_count;
    axil_pkg::axil_data_t      beat_count;
    logic                      wr_busy;

    axis_to_memory u_writer (
        .axis_clk, .axis_aresetn,
        .axis_tdata, .axis_tkeep, .axis_tlast, .axis_tvalid, .axis_tready,
        .heap_wr_start_addr,
        .heap_a_addr, .heap_a_wr_data, .heap_a_wr_en,
        .pkt_count, .beat_count, .wr_busy
    );

    heap_bram u_heap (
        .axis_clk,
        .heap_a_addr, .heap_a_wr_data, .heap_a_wr_en,
        .heap_b_addr, .heap_b_rd_data
    );

    heap_ctrl_regs u_regs (
        .axis_clk, .axis_aresetn,
        .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
        .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
        .heap_wr_start_addr, .pkt_count, .beat_count, .wr_busy,
        .heap_b_addr, .heap_b_rd_data
    );

endmodule

// File: hdl/heap_ctrl_regs.sv
// AXI4-Lite slave: start address, counters, status and the heap read window.
`include "heap_settings.svh"

module heap_ctrl_regs (
    input  logic                      axis_clk,
    input  logic                      axis_aresetn,

    input  axil_pkg::axil_addr_t      s_axil_awaddr,
    input  logic                      s_axil_awvalid,
    output logic                      s_axil_awready,
    input  axil_pkg::axil_data_t      s_axil_wdata,
    input  logic [3:0]                s_axil_wstrb,
    input  logic                      s_axil_wvalid,
    output logic                      s_axil_wready,
    output axil_pkg::axil_resp_t      s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  logic                      s_axil_bready,
    input  axil_pkg::axil_addr_t      s_axil_araddr,
    input  logic                      s_axil_arvalid,
    output logic                      s_axil_arready,
    output axil_pkg::axil_data_t      s_axil_rdata,
    output axil_pkg::axil_resp_t      s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  logic                      s_axil_rready,

    output heap_pkg::heap_byte_addr_t heap_wr_start_addr,
    input  axil_pkg::axil_data_t      pkt_count,
    input  axil_pkg::axil_data_t      beat_count,
    input  logic                      wr_busy,

    output heap_pkg::heap_byte_addr_t heap_b_addr,
    input  heap_pkg::heap_word_t      heap_b_rd_data
);

    axil_pkg::axil_state_t state;
    axil_pkg::axil_data_t  rdata_q;
    axil_pkg::axil_data_t  reg_rdata;
    axil_pkg::axil_addr_t  wr_word_addr;
    axil_pkg::axil_addr_t  rd_word_addr;
    logic                  wr_take;
    logic                  rd_take;
    logic                  wr_hit_start;
    logic                  rd_in_window;
    logic                  rd_ok;
    logic                  rd_from_heap;

    // write wins when both arrive together.
    assign wr_take = (state == axil_pkg::IDLE) && s_axil_awvalid && s_axil_wvalid;
    assign rd_take = (state == axil_pkg::IDLE) && s_axil_arvalid &&
                     !s_axil_awvalid && !s_axil_wvalid;

    assign s_axil_awready = wr_take;
    assign s_axil_wready  = wr_take;
    assign s_axil_arready = rd_take;

    assign wr_word_addr = {s_axil_awaddr[`AXIL_ADDR_BITS-1:2], 2'b00};
    assign rd_word_addr = {s_axil_araddr[`AXIL_ADDR_BITS-1:2], 2'b00};
    assign wr_hit_start = (wr_word_addr == `REG_START_ADDR);
    assign rd_in_window = (s_axil_araddr >= `HEAP_WINDOW_BASE);

    // ------------------------------------------------------------------
    // read decode
    // ------------------------------------------------------------------
    always_comb begin
        rd_ok     = 1'b1;
        reg_rdata = '0;
        case (rd_word_addr)
            `REG_START_ADDR: reg_rdata = axil_pkg::axil_data_t'(heap_wr_start_addr);
            `REG_PKT_COUNT:  reg_rdata = pkt_count;
            `REG_BEAT_COUNT: reg_rdata = beat_count;
            `REG_STATUS:     reg_rdata = {31'b0, wr_busy};
            default:         rd_ok     = rd_in_window; // window data comes later.
        endcase
    end

    // ------------------------------------------------------------------
    // transaction state and register file
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge axis_aresetn) begin
        if (!axis_aresetn) begin
            state              <= axil_pkg::IDLE;
            s_axil_bvalid      <= 1'b0;
            s_axil_rvalid      <= 1'b0;
            heap_wr_start_addr <= '0;
        end else begin
            case (state)
                axil_pkg::IDLE: begin
                    if (wr_take) begin
                        if (wr_hit_start) begin
                            for (int i = 0; i < `HEAP_ADDR_BITS; i++) begin
                                if (s_axil_wstrb[i/8]) heap_wr_start_addr[i] <= s_axil_wdata[i];
                            end
                        end
                        s_axil_bvalid <= 1'b1;
                        state         <= axil_pkg::WRITE_RESP;
                    end else if (rd_take) begin
                        if (rd_in_window) begin
                            state <= axil_pkg::READ_WAIT;
                        end else begin
                            s_axil_rvalid <= 1'b1;
                            state         <= axil_pkg::READ_RESP;
                        end
                    end
                end
                axil_pkg::WRITE_RESP: begin
                    if (s_axil_bready) begin
                        s_axil_bvalid <= 1'b0;
                        state         <= axil_pkg::IDLE;
                    end
                end
                axil_pkg::READ_WAIT: begin
                    s_axil_rvalid <= 1'b1;
                    state         <= axil_pkg::READ_RESP;
                end
                axil_pkg::READ_RESP: begin
                    if (s_axil_rready) begin
                        s_axil_rvalid <= 1'b0;
                        state         <= axil_pkg::IDLE;
                    end
                end
                default: state <= axil_pkg::IDLE;
            endcase
        end
    end

    // response payload, captured at acceptance.
    always_ff @(posedge axis_clk) begin
        if (wr_take) s_axil_bresp <= wr_hit_start ? axil_pkg::OKAY : axil_pkg::SLVERR;
        if (rd_take) begin
            s_axil_rresp <= rd_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
            rdata_q      <= reg_rdata;
            rd_from_heap <= rd_in_window;
            heap_b_addr  <= s_axil_araddr[`HEAP_ADDR_BITS-1:0];
        end
    end

    // window data straight from the heap read register.
    assign s_axil_rdata = rd_from_heap ? heap_b_rd_data : rdata_q;

    a_one_response: assert property (@(posedge axis_clk) disable iff (!axis_aresetn)
        !(s_axil_bvalid && s_axil_rvalid));

endmodule

// File: hdl/heap_bram.sv
// heap memory: simple dual port, byte-enabled write on port A, registered read on port B.
`include "heap_settings.svh"

module heap_bram (
    input  logic                      axis_clk,

    input  heap_pkg::heap_byte_addr_t heap_a_addr,
    input  heap_pkg::heap_word_t      heap_a_wr_data,
    input  heap_pkg::heap_strb_t      heap_a_wr_en,

    input  heap_pkg::heap_byte_addr_t heap_b_addr,
    output heap_pkg::heap_word_t      heap_b_rd_data
);

    heap_pkg::heap_word_t  mem [`HEAP_DEPTH_WORDS];
    heap_pkg::heap_index_t a_index;
    heap_pkg::heap_index_t b_index;

    // byte address to word index.
    assign a_index = heap_a_addr[`HEAP_ADDR_BITS-1:2];
    assign b_index = heap_b_addr[`HEAP_ADDR_BITS-1:2];

    // ------------------------------------------------------------------
    // port A, one enable per byte lane
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (heap_a_wr_en[lane]) begin
                mem[a_index][lane*8 +: 8] <= heap_a_wr_data[lane*8 +: 8];
            end
        end
    end

    // ------------------------------------------------------------------
    // port B, read only
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk) begin
        heap_b_rd_data <= mem[b_index]; // one cycle latency.
    end

endmodule

// File: hdl/axis_to_memory.sv
// stream-to-heap writer: packet state machine, port A address generation, beat and packet counters.
`include "heap_settings.svh"

module axis_to_memory (
    input  logic                      axis_clk,
    input  logic                      axis_aresetn,

    input  heap_pkg::heap_word_t      axis_tdata,
    input  heap_pkg::heap_strb_t      axis_tkeep,
    input  logic                      axis_tlast,
    input  logic                      axis_tvalid,
    output logic                      axis_tready,

    input  heap_pkg::heap_byte_addr_t heap_wr_start_addr,

    output heap_pkg::heap_byte_addr_t heap_a_addr,
    output heap_pkg::heap_word_t      heap_a_wr_data,
    output heap_pkg::heap_strb_t      heap_a_wr_en,

    output axil_pkg::axil_data_t      pkt_count,
    output axil_pkg::axil_data_t      beat_count,
    output logic                      wr_busy
);

    heap_pkg::pkt_state_t state;
    heap_pkg::pkt_state_t next_state;
    logic                 beat;

    assign beat    = axis_tvalid && axis_tready;
    assign wr_busy = (state == heap_pkg::WRITING);

    // ------------------------------------------------------------------
    // packet state machine
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge axis_aresetn) begin
        if (!axis_aresetn) begin
            state <= heap_pkg::START_WRITE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            heap_pkg::START_WRITE: begin
                if (beat && !axis_tlast) next_state = heap_pkg::WRITING; // single beat stays.
            end
            heap_pkg::WRITING: begin
                if (beat && axis_tlast) next_state = heap_pkg::START_WRITE;
            end
            default: next_state = heap_pkg::START_WRITE;
        endcase
    end

    // ------------------------------------------------------------------
    // port A write, one registered write per accepted beat
    // ------------------------------------------------------------------
    always_ff @(posedge axis_clk or negedge axis_aresetn) begin
        if (!axis_aresetn) begin
            heap_a_addr  <= '0;
            heap_a_wr_en <= '0;
        end else begin
            heap_a_wr_en <= beat ? axis_tkeep : '0;
            if (beat) begin
                if (state == heap_pkg::START_WRITE) begin
                    heap_a_addr <= {heap_wr_start_addr[`HEAP_ADDR_BITS-1:2], 2'b00};
                end else begin
                    heap_a_addr <= heap_a_addr + heap_pkg::heap_byte_addr_t'(4); // wraps.
                end
            end
            // no beat, address held so the packet stays contiguous.
        end
    end

    always_ff @(posedge axis_clk) begin
        if (beat) heap_a_wr_data <= axis_tdata;
    end

    always_ff @(posedge axis_clk or negedge axis_aresetn) begin
        if (!axis_aresetn) begin
            beat_count  <= '0;
            pkt_count   <= '0;
            axis_tready <= 1'b0;
        end else begin
            axis_tready <= 1'b1; // never back-pressures.
            if (beat) beat_count <= beat_count + 1'b1;
            if (beat && axis_tlast) pkt_count <= pkt_count + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    a_idle_no_write: assert property (@(posedge axis_clk) disable iff (!axis_aresetn)
        !beat |=> (heap_a_wr_en == '0));

    a_tready_sticky: assert property (@(posedge axis_clk) disable iff (!axis_aresetn)
        axis_tready |=> axis_tready);

endmodule

// File: hdl/axil_pkg.sv
// AXI4-Lite types: bus address, bus data, response code, slave state.
`include "heap_settings.svh"

package axil_pkg;

    typedef logic [`AXIL_ADDR_BITS-1:0] axil_addr_t;
    typedef logic [31:0]                axil_data_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

    // one transaction in flight at a time.
    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP, // bvalid held until bready.
        READ_WAIT,  // heap read latency.
        READ_RESP   // rvalid held until rready.
    } axil_state_t;

endpackage

// File: hdl/heap_pkg.sv
// heap-side types: byte address, data word, byte strobe, word index, packet state.
`include "heap_settings.svh"

package heap_pkg;

    typedef logic [`HEAP_ADDR_BITS-1:0] heap_byte_addr_t;
    typedef logic [31:0]                heap_word_t;
    typedef logic [3:0]                 heap_strb_t;

    // word index drops the two byte-select bits.
    typedef logic [`HEAP_ADDR_BITS-3:0] heap_index_t;

    // stream packet tracking.
    typedef enum logic {
        START_WRITE,
        WRITING
    } pkt_state_t;

endpackage

// File: include/heap_settings.svh
// heap geometry, AXI4-Lite address width and control register map.
`ifndef HEAP_SETTINGS_SVH
`define HEAP_SETTINGS_SVH

// ----------------------------------------------------------------------
// heap geometry
// ----------------------------------------------------------------------
`define HEAP_DEPTH_WORDS 1024 // 4 KB of 32-bit words.
`define HEAP_ADDR_BITS   12   // byte address, log2 of heap bytes.

// ----------------------------------------------------------------------
// AXI4-Lite register map
// ----------------------------------------------------------------------
`define AXIL_ADDR_BITS   13

`define REG_START_ADDR   32'h0000_0000 // packet start byte address, rw.
`define REG_PKT_COUNT    32'h0000_0004 // packets seen, ro.
`define REG_BEAT_COUNT   32'h0000_0008 // beats seen, ro.
`define REG_STATUS       32'h0000_000C // bit 0 is writer busy, ro.

// reads from here up to the top of the AXI4-Lite space go to the heap.
`define HEAP_WINDOW_BASE 32'h0000_1000

`endif
